/* flist.f */
+incdir+.
audio_pkg.sv
ctrl_pkg.sv
sample_ram.sv
rate_gen.sv
cic_interp.sv
volume_ctrl.sv
i2s_tx.sv
audio_dac_top.sv
tb_audio_dac.sv

/* run.sh */
#!/bin/sh
# Build and run the audio DAC testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_audio_dac
./obj_dir/Vtb_audio_dac | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

/* tb_audio_dac.sv */
`timescale 1ns/1ps

`include "audio_defines.svh"

module tb_audio_dac
  import audio_pkg::*;
  import ctrl_pkg::*;
();

  localparam int CLK_PERIOD     = 4;
  localparam int SYSCLK_CYCLES  = 4;      // sysclk period in clkin cycles
  localparam int NUM_ROWS       = 9;
  localparam int STABLE_FRAMES  = 32;     // Longer than the CIC transient
  localparam int SETTLE_FRAMES  = 1100;   // Full gain ramp plus CIC settling
  localparam int PAIR_TIMEOUT   = 2048;
  localparam int STATUS_TIMEOUT =
    256 * `CIC_RATE * SYSCLK_CYCLES * (`NTSC_DIV / `NTSC_MUL + 1) + 50000;

  // One stimulus row
  typedef struct packed {
    sample_t    fill;
    logic [7:0] volume;
    vol_step_e  step;
    logic       play;
    logic       pal;
    sample_t    expect_word;
  } row_t;

  logic       clkin;
  logic       sysclk;
  logic       reset;
  logic       we;
  byte_addr_t pgm_address;
  logic [7:0] pgm_data;
  logic [7:0] volume;
  logic       vol_latch;
  vol_step_e  vol_select;
  logic       play;
  logic       palmode;
  logic       sdout;
  logic       mclk_out;
  logic       lrck_out;
  logic       sclk_out;
  logic       dac_status;

  integer seed;

  // I2S receiver state
  logic [15:0] rx_shift   = '0;
  logic        rx_lrck    = 1'b1;
  bit          rx_started = 1'b0;
  int          rise_cnt   = 0;
  int          pair_cnt   = 0;
  sample_t     left_word  = '0;
  sample_t     right_word = '0;
  longint      mclk_last  = -1;
  longint      sclk_last  = -1;

  // Gain targets are v + v7, 2v + 2*v7 and 4v + top two bits
  row_t stim [NUM_ROWS] = '{
    '{16'h0000, 8'h80, db0,  1'b0, 1'b0, 16'h0000},   // Silence over random data
    '{16'h0000, 8'hff, db12, 1'b0, 1'b0, 16'h0000},
    '{16'h1234, 8'h00, db0,  1'b0, 1'b0, 16'h0000},   // Gain ramps down to 0
    '{16'h1234, 8'hff, db0,  1'b0, 1'b0, 16'h1234},   // Unity, ramp from 0
    '{16'h1000, 8'h80, db6,  1'b0, 1'b0, 16'h1020},   // Gain 258
    '{16'h0800, 8'h40, db12, 1'b0, 1'b0, 16'h0808},   // Gain 257
    '{16'h4000, 8'hff, db12, 1'b0, 1'b0, 16'h7fff},   // Clips high
    '{16'hc000, 8'hff, db12, 1'b0, 1'b1, 16'h8000},   // Clips low, PAL rate
    '{16'h0f00, 8'hff, db0,  1'b1, 1'b0, 16'h0f00}    // Playback running
  };

  audio_dac_top audio_dac_top_inst (
    .clkin, .sysclk, .reset, .we, .pgm_address, .pgm_data,
    .volume, .vol_latch, .vol_select, .play, .palmode,
    .sdout, .mclk_out, .lrck_out, .sclk_out, .dac_status
  );

  initial begin
    clkin = 1'b0;
    forever #(CLK_PERIOD / 2) clkin = ~clkin;
  end

  initial begin
    sysclk = 1'b0;
    forever begin
      repeat (SYSCLK_CYCLES / 2) @(posedge clkin);
      sysclk <= ~sysclk;
    end
  end

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////
  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic report_failure(input string why);
    $display("ERROR: %s", why);
    abort_run();
  endtask

  //////////////////////////////////////////////////
  // I2S receiver and clock monitors
  //////////////////////////////////////////////////
  always @(posedge sclk_out) begin
    rx_shift = {rx_shift[14:0], sdout};
    if (lrck_out != rx_lrck) begin        // First bit slot of a new half
      if (rx_started) begin
        check_value("sclk_out rises per lrck half", rise_cnt, 16);
        if (rx_lrck) begin
          left_word = rx_shift;
        end else begin
          right_word = rx_shift;
          pair_cnt++;
        end
      end
      rx_started = 1'b1;
      rx_lrck    = lrck_out;
      rise_cnt   = 1;
    end else begin
      rise_cnt++;
    end
  end

  always @(posedge sclk_out) begin
    if (reset) begin
      sclk_last = -1;
    end else begin
      if (sclk_last >= 0)
        check_value("sclk_out period", 32'(($time - sclk_last) / CLK_PERIOD), 16);
      sclk_last = $time;
    end
  end

  always @(posedge mclk_out) begin
    if (reset) begin
      mclk_last = -1;
    end else begin
      if (mclk_last >= 0)
        check_value("mclk_out period", 32'(($time - mclk_last) / CLK_PERIOD), 8);
      mclk_last = $time;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////
  task automatic fill_ram(input sample_t value, input bit random_data);
    logic [31:0] word;
    int          b;
    word = {value, value};                // Left high, right low
    for (b = 0; b < `RAM_DEPTH * 4; b++) begin
      @(posedge clkin);
      we          <= 1'b0;
      pgm_address <= byte_addr_t'(b);
      pgm_data    <= random_data ? 8'($random(seed)) : word[8 * (b % 4) +: 8];
    end
    @(posedge clkin);
    we <= 1'b1;
  endtask

  task automatic latch_volume(input logic [7:0] vol, input vol_step_e step);
    @(posedge clkin);
    volume     <= vol;
    vol_select <= step;
    vol_latch  <= 1'b1;
    repeat (4) @(posedge clkin);
    vol_latch  <= 1'b0;
    volume     <= ~vol;                   // Only the latched byte may reach the gain
  endtask

  // Blocks until the receiver has one more left and right word
  task automatic wait_word_pair();
    int seen;
    int cyc;
    seen = pair_cnt;
    cyc  = 0;
    while (pair_cnt == seen && cyc < PAIR_TIMEOUT) begin
      @(negedge clkin);
      cyc++;
    end
    if (pair_cnt == seen) report_failure("no I2S word pair arrived in time");
  endtask

  // Waits until both channels hold the expected word for a run of frames
  task automatic wait_settled(input sample_t expect_word, input bit ramp_check);
    int      frames;
    int      stable;
    sample_t last_left;
    frames    = 0;
    stable    = 0;
    last_left = left_word;
    while (stable < STABLE_FRAMES) begin
      wait_word_pair();
      frames++;
      if (ramp_check && left_word < last_left)
        report_failure("left word fell while the gain ramped up");
      last_left = left_word;
      if (left_word == expect_word && right_word == expect_word) stable++;
      else stable = 0;
      if (stable < STABLE_FRAMES && frames > SETTLE_FRAMES) begin
        check_value("left word", $unsigned(left_word), $unsigned(expect_word));
        check_value("right word", $unsigned(right_word), $unsigned(expect_word));
        report_failure("I2S output did not hold a settled value");
      end
    end
    check_value("left word", $unsigned(left_word), $unsigned(expect_word));
    check_value("right word", $unsigned(right_word), $unsigned(expect_word));
  endtask

  task automatic apply_row(input row_t row, input bit ramp_check);
    int cyc;
    @(posedge clkin);
    play    <= row.play;
    palmode <= row.pal;
    wait_word_pair();                     // Strobe burst after a ratio change sees old data
    fill_ram(row.fill, 1'b0);
    latch_volume(row.volume, row.step);
    wait_settled(row.expect_word, ramp_check);
    if (row.play) begin
      cyc = 0;
      while (dac_status !== 1'b1 && cyc < STATUS_TIMEOUT) begin
        @(negedge clkin);
        cyc++;
      end
      if (dac_status !== 1'b1) report_failure("dac_status never rose with play high");
    end else begin
      @(negedge clkin);
      check_value("dac_status", dac_status, 0);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    seed        = 62;
    reset       = 1'b1;
    we          = 1'b1;
    pgm_address = '0;
    pgm_data    = '0;
    volume      = '0;
    vol_latch   = 1'b0;
    vol_select  = db0;
    play        = 1'b0;
    palmode     = 1'b0;
    repeat (5) @(posedge clkin);
    reset <= 1'b0;
    fill_ram('0, 1'b1);                   // Random contents first
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(stim[r], (r > 0) && (stim[r].fill == stim[r - 1].fill));
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* audio_dac_top.sv */
`timescale 1ns/1ps

module audio_dac_top
  import audio_pkg::*;
  import ctrl_pkg::*;
(
  input  logic       clkin,
  input  logic       sysclk,
  input  logic       reset,
  input  logic       we,
  input  byte_addr_t pgm_address,
  input  logic [7:0] pgm_data,
  input  logic [7:0] volume,
  input  logic       vol_latch,
  input  vol_step_e  vol_select,
  input  logic       play,
  input  logic       palmode,
  output logic       sdout,
  output logic       mclk_out,
  output logic       lrck_out,
  output logic       sclk_out,
  output logic       dac_status
);

  addr_t  dac_address;
  frame_t ram_frame;
  frame_t cic_frame;
  logic   int_strobe;
  logic   comb_strobe;
  logic   frame_tick;
  gain_t  gain;

  sample_ram sample_ram_inst (
    .clkin, .we, .pgm_address, .pgm_data,
    .dac_address, .frame_out(ram_frame)
  );

  rate_gen rate_gen_inst (
    .clkin, .reset, .sysclk, .palmode, .play, .frame_tick,
    .int_strobe, .comb_strobe, .dac_address, .dac_status
  );

  cic_interp cic_interp_inst (
    .clkin, .reset, .int_strobe, .comb_strobe,
    .frame_in(ram_frame), .frame_out(cic_frame)
  );

  volume_ctrl volume_ctrl_inst (
    .clkin, .reset, .volume, .vol_select, .vol_latch, .frame_tick, .gain
  );

  i2s_tx i2s_tx_inst (
    .clkin, .reset, .frame_in(cic_frame), .gain, .frame_tick,
    .mclk_out, .lrck_out, .sclk_out, .sdout
  );

endmodule

/* i2s_tx.sv */
`timescale 1ns/1ps

`include "audio_defines.svh"

module i2s_tx
  import audio_pkg::*;
  import ctrl_pkg::*;
(
  input  logic   clkin,
  input  logic   reset,
  input  frame_t frame_in,
  input  gain_t  gain,
  output logic   frame_tick,
  output logic   mclk_out,
  output logic   lrck_out,
  output logic   sclk_out,
  output logic   sdout
);

  localparam int SMP_W  = $bits(sample_t);
  localparam int PROD_W = SMP_W + $bits(gain_t) + 1;
  localparam int SHIFT  = 8;                         // Gain of 256 is unity

  logic [`DIV_W-1:0] div_cnt;
  logic [1:0]        mclk_sreg;
  logic [1:0]        lrck_sreg;
  logic [1:0]        sclk_sreg;
  logic              sclk_fall;
  logic              lrck_edge;

  sample_t                          chan;
  logic signed [PROD_W-1:0]         product;
  logic [PROD_W-SHIFT-SMP_W:0]      prod_hi;
  sample_t                          sat;
  logic [SMP_W-1:0]                 shift_reg;

  //////////////////////////////////////////////////
  // Clock generation
  //////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (reset) begin
      div_cnt   <= `DIV_INIT;                       // Start mid-period, lrck high
      mclk_sreg <= 2'b00;
      sclk_sreg <= 2'b00;
      lrck_sreg <= 2'b11;
    end else begin
      div_cnt   <= div_cnt + 1'b1;
      mclk_sreg <= {mclk_sreg[0], div_cnt[`MCLK_BIT]};
      sclk_sreg <= {sclk_sreg[0], div_cnt[`SCLK_BIT]};
      lrck_sreg <= {lrck_sreg[0], div_cnt[`LRCK_BIT]};
    end
  end

  assign mclk_out   = ~mclk_sreg[1];
  assign sclk_out   = sclk_sreg[1];
  assign lrck_out   = lrck_sreg[1];
  assign frame_tick = (lrck_sreg == 2'b01);
  assign lrck_edge  = lrck_sreg[1] ^ lrck_sreg[0];
  assign sclk_fall  = (sclk_sreg == 2'b10);

  //////////////////////////////////////////////////
  // Gain and saturation
  //////////////////////////////////////////////////
  assign chan    = lrck_sreg[0] ? frame_in.left : frame_in.right;   // High is left
  assign product = chan * $signed({1'b0, gain});
  assign prod_hi = product[PROD_W-1:SHIFT+SMP_W-1];

  always_comb begin
    if (prod_hi == '0 || prod_hi == '1) begin
      sat = product[SHIFT +: SMP_W];
    end else begin
      sat = product[PROD_W-1] ? 16'sh8000 : 16'sh7fff;   // Clip to full scale
    end
  end

  // MSB first, one bit per sclk fall
  always_ff @(posedge clkin) begin
    if (reset) begin
      shift_reg <= '0;
      sdout     <= 1'b0;
    end else if (sclk_fall) begin
      sdout <= shift_reg[SMP_W-1];
      if (lrck_edge) begin
        shift_reg <= sat;
      end else begin
        shift_reg <= {shift_reg[SMP_W-2:0], 1'b0};
      end
    end
  end

endmodule

/* volume_ctrl.sv */
`timescale 1ns/1ps

module volume_ctrl
  import ctrl_pkg::*;
(
  input  logic       clkin,
  input  logic       reset,
  input  logic [7:0] volume,
  input  vol_step_e  vol_select,
  input  logic       vol_latch,
  input  logic       frame_tick,
  output gain_t      gain
);

  logic [1:0] latch_sreg;
  logic       latch_rise;
  vol_cfg_t   cfg;
  logic [7:0] vol_v;
  logic       vol_msb;
  gain_t      scaled;
  gain_t      target;

  always_ff @(posedge clkin) begin
    if (reset) begin
      latch_sreg <= 2'b00;
    end else begin
      latch_sreg <= {latch_sreg[0], vol_latch};
    end
  end

  assign latch_rise = (latch_sreg == 2'b01);

  always_ff @(posedge clkin) begin
    if (reset) begin
      cfg <= '{volume: 8'h00, step: db0};
    end else if (latch_rise) begin
      cfg <= '{volume: volume, step: vol_select};
    end
  end

  assign vol_v   = cfg.volume;
  assign vol_msb = cfg.volume[7];   // Lets FF reach exactly 256

  //////////////////////////////////////////////////
  // Shift-and-add dB approximations
  //////////////////////////////////////////////////
  always_comb begin
    case (cfg.step)
      db3:     scaled = gain_t'(vol_v) + gain_t'(vol_v[7:1]) + gain_t'(vol_msb);
      db6:     scaled = gain_t'({vol_v, 1'b0}) + gain_t'({vol_msb, 1'b0});
      db9:     scaled = gain_t'({vol_v, 1'b0}) + gain_t'(vol_v) + gain_t'(vol_v[7:6]);
      db12:    scaled = gain_t'({vol_v, vol_v[7:6]});
      default: scaled = gain_t'(vol_v) + gain_t'(vol_msb);    // 0 dB
    endcase
  end

  always_ff @(posedge clkin) begin
    if (reset) begin
      target <= '0;
      gain   <= '0;
    end else begin
      target <= scaled;
      if (frame_tick) begin             // Ramp one step per audio frame
        if (gain > target) begin
          gain <= gain - 1'b1;
        end else if (gain < target) begin
          gain <= gain + 1'b1;
        end
      end
    end
  end

  a_gain_ramp: assert property (@(posedge clkin) disable iff (reset)
    $changed(gain) |-> $past(frame_tick) &&
      ((gain - $past(gain) == 1) || ($past(gain) - gain == 1)));

endmodule

/* cic_interp.sv */
`timescale 1ns/1ps

`include "audio_defines.svh"

module cic_interp
  import audio_pkg::*;
  import ctrl_pkg::*;
(
  input  logic   clkin,
  input  logic   reset,
  input  logic   int_strobe,
  input  logic   comb_strobe,
  input  frame_t frame_in,
  output frame_t frame_out
);

  // DC gain of three held stages at rate R is R^3
  localparam int OUT_LSB = 3 * $clog2(`CIC_RATE);
  localparam int SMP_W   = $bits(sample_t);

  cic_state_e state;

  acc_t chan_in [2];       // 0 left, 1 right
  acc_t comb_z  [2][3];    // Comb delay elements
  acc_t comb_o  [2][3];    // Comb outputs
  acc_t integ   [2][3];    // Integrator sums

  always_comb begin
    chan_in[0] = acc_t'(frame_in.left);
    chan_in[1] = acc_t'(frame_in.right);
  end

  always_ff @(posedge clkin) begin
    if (reset) begin
      state <= idle;
      for (int ch = 0; ch < 2; ch++) begin
        for (int k = 0; k < 3; k++) begin
          comb_z[ch][k] <= '0;
          comb_o[ch][k] <= '0;
          integ[ch][k]  <= '0;
        end
      end
    end else if (int_strobe) begin
      state <= comb_strobe ? comb1 : int1;   // Restart on every strobe
    end else begin
      case (state)
        //////////////////////////////////////////////////
        // Combs, once per frame
        //////////////////////////////////////////////////
        comb1: begin
          for (int ch = 0; ch < 2; ch++) begin
            comb_z[ch][0] <= chan_in[ch];
            comb_o[ch][0] <= chan_in[ch] - comb_z[ch][0];
          end
          state <= comb2;
        end
        comb2: begin
          for (int ch = 0; ch < 2; ch++) begin
            comb_z[ch][1] <= comb_o[ch][0];
            comb_o[ch][1] <= comb_o[ch][0] - comb_z[ch][1];
          end
          state <= comb3;
        end
        comb3: begin
          for (int ch = 0; ch < 2; ch++) begin
            comb_z[ch][2] <= comb_o[ch][1];
            comb_o[ch][2] <= comb_o[ch][1] - comb_z[ch][2];
          end
          state <= int1;
        end
        //////////////////////////////////////////////////
        // Integrators, every strobe
        //////////////////////////////////////////////////
        int1: begin
          for (int ch = 0; ch < 2; ch++) begin
            integ[ch][0] <= integ[ch][0] + comb_o[ch][2];   // Last comb output held
          end
          state <= int2;
        end
        int2: begin
          for (int ch = 0; ch < 2; ch++) begin
            integ[ch][1] <= integ[ch][1] + integ[ch][0];
          end
          state <= int3;
        end
        int3: begin
          for (int ch = 0; ch < 2; ch++) begin
            integ[ch][2] <= integ[ch][2] + integ[ch][1];
          end
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // Output moves only when the last integrator does
  assign frame_out.left  = integ[0][2][OUT_LSB +: SMP_W];
  assign frame_out.right = integ[1][2][OUT_LSB +: SMP_W];

  a_state_legal: assert property (@(posedge clkin) disable iff (reset)
    state inside {idle, comb1, comb2, comb3, int1, int2, int3});

endmodule

/* rate_gen.sv */
`timescale 1ns/1ps

`include "audio_defines.svh"

module rate_gen
  import audio_pkg::*;
(
  input  logic  clkin,
  input  logic  reset,
  input  logic  sysclk,
  input  logic  palmode,
  input  logic  play,
  input  logic  frame_tick,
  output logic  int_strobe,
  output logic  comb_strobe,
  output addr_t dac_address,
  output logic  dac_status
);

  localparam int SUB_W = $clog2(`CIC_RATE);

  logic [2:0]          sysclk_sreg;
  logic                sysclk_rise;
  logic                play_r;
  logic [`PHASE_W-1:0] phase_acc;
  logic [`PHASE_W-1:0] phase_mul;
  logic [`PHASE_W-1:0] phase_div;
  logic [SUB_W-1:0]    sub_cnt;
  addr_t               addr_raw;
  addr_t               addr_sync;

  always_ff @(posedge clkin) begin
    sysclk_sreg <= {sysclk_sreg[1:0], sysclk};
    play_r      <= play;
  end

  assign sysclk_rise = (sysclk_sreg[2:1] == 2'b01);

  assign phase_mul = palmode ? `PHASE_W'(`PAL_MUL) : `PHASE_W'(`NTSC_MUL);
  assign phase_div = palmode ? `PHASE_W'(`PAL_DIV) : `PHASE_W'(`NTSC_DIV);

  //////////////////////////////////////////////////
  // Fractional divider, one strobe per overflow
  //////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    int_strobe  <= 1'b0;
    comb_strobe <= 1'b0;
    if (reset) begin
      phase_acc <= '0;
      sub_cnt   <= '0;
      addr_raw  <= '0;
    end else if (sysclk_rise) begin
      if (phase_acc >= phase_div) begin
        phase_acc  <= phase_acc - phase_div + phase_mul;
        sub_cnt    <= sub_cnt + 1'b1;
        int_strobe <= 1'b1;
        if (sub_cnt == '0) begin                   // New frame for the CIC
          comb_strobe <= 1'b1;
          addr_raw    <= addr_raw + addr_t'(play_r);
        end
      end else begin
        phase_acc <= phase_acc + phase_mul;
      end
    end
  end

  // Address seen by the RAM only moves at frame boundaries
  always_ff @(posedge clkin) begin
    if (reset) begin
      addr_sync <= '0;
    end else if (frame_tick) begin
      addr_sync <= addr_raw;
    end
  end

  assign dac_address = addr_sync;
  assign dac_status  = addr_raw[`ADDR_W-1];    // Buffer half indicator

  a_comb_in_int: assert property (@(posedge clkin) disable iff (reset)
    comb_strobe |-> int_strobe);

endmodule

/* sample_ram.sv */
`timescale 1ns/1ps

`include "audio_defines.svh"

module sample_ram
  import audio_pkg::*;
(
  input  logic       clkin,
  input  logic       we,            // Active low
  input  byte_addr_t pgm_address,
  input  logic [7:0] pgm_data,
  input  addr_t      dac_address,
  output frame_t     frame_out
);

  logic [$bits(frame_t)-1:0] mem [`RAM_DEPTH];

  addr_t      wr_frame;
  logic [1:0] wr_lane;

  assign wr_frame = pgm_address[`BYTE_ADDR_W-1:2];
  assign wr_lane  = pgm_address[1:0];

  // Host side, one byte lane per write
  always_ff @(posedge clkin) begin
    if (!we) begin
      mem[wr_frame][{wr_lane, 3'b000} +: 8] <= pgm_data;   // Lane 0 is the low byte
    end
  end

  // Playback side
  always_ff @(posedge clkin) begin
    frame_out <= frame_t'(mem[dac_address]);
  end

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

  typedef logic [10:0] gain_t;                    // 256 is unity

  // Volume boost selection
  typedef enum logic [2:0] {
    db0  = 3'd0,
    db3  = 3'd1,
    db6  = 3'd2,
    db9  = 3'd3,
    db12 = 3'd4
  } vol_step_e;

  // Interpolator sequencer
  typedef enum logic [2:0] {
    idle, comb1, comb2, comb3, int1, int2, int3
  } cic_state_e;

  typedef struct packed {
    logic [7:0] volume;
    vol_step_e  step;
  } vol_cfg_t;

endpackage

/* audio_pkg.sv */
package audio_pkg;

  `include "audio_defines.svh"

  //////////////////////////////////////////////////
  // Sample data
  //////////////////////////////////////////////////

  typedef logic signed [15:0] sample_t;           // One channel, two's complement

  // Left sits in the upper half of the 32-bit word
  typedef struct packed {
    sample_t left;
    sample_t right;
  } frame_t;

  typedef logic signed [`CIC_W-1:0] acc_t;        // CIC accumulator per channel

  //////////////////////////////////////////////////
  // Buffer addressing
  //////////////////////////////////////////////////

  typedef logic [`ADDR_W-1:0]      addr_t;         // Frame address
  typedef logic [`BYTE_ADDR_W-1:0] byte_addr_t;    // Host byte address

endpackage

/* audio_defines.svh */
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// Sample buffer geometry
`define ADDR_W       9
`define BYTE_ADDR_W  11
`define RAM_DEPTH    512

// Console clock to 16 x 44.1 kHz ratios
`define NTSC_MUL     1232
`define NTSC_DIV     37500
`define PAL_MUL      23520
`define PAL_DIV      709379
`define PHASE_W      20

// Interpolator
`define CIC_RATE     16
`define CIC_W        32

// I2S divider and its taps
`define DIV_W        11
`define DIV_INIT     11'h100
`define MCLK_BIT     2
`define SCLK_BIT     3
`define LRCK_BIT     8

`endif
